//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --timing -Wno-fatal --top-module rotBank_tb -f rotBank.f
	out="$$(./obj_dir/VrotBank_tb +verilator+error+limit+100)"; echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

//--- design/laneCollect.sv
// Output vector register and per-lane saturation counters that stick at all ones
`timescale 1ns/1ps

module laneCollect (
  input  logic                                          clk,
  input  logic                                          rst,
  input  rotPkg::cfgT                                   cfg,
  input  rotPkg::vecT                                   laneOut,
  input  logic [rotPkg::NUM_LANES-1:0]                  laneSat,
  input  logic                                          laneValid, // Lane 0 stands for all
  output rotPkg::vecT                                   outVec,
  output logic                                          outValid,
  output logic [rotPkg::NUM_LANES-1:0][rotPkg::CNT_W-1:0] satCount
);

  localparam logic [rotPkg::CNT_W-1:0] CNT_MAX = '1;

  always_ff @(posedge clk) begin
    outVec <= laneOut;
  end

  always_ff @(posedge clk) begin
    if (rst) outValid <= 1'b0;
    else     outValid <= laneValid;
  end

  // ------------------------------------------------------------------
  // Saturation counters
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst || cfg.satClear) begin
      satCount <= '0;
    end else if (laneValid) begin
      for (int i = 0; i < rotPkg::NUM_LANES; i++) begin
        if (laneSat[i] && satCount[i] != CNT_MAX) begin
          satCount[i] <= satCount[i] + 1'b1;
        end
      end
    end
  end

endmodule

//--- design/phaseNco.sv
// Phase accumulator with a full 1024-entry cosine/sine ROM per lane; advances only on enabled input
`timescale 1ns/1ps

module phaseNco (
  input  logic        clk,
  input  logic        rst,
  input  rotPkg::cfgT cfg,
  input  rotPkg::vecT inVec,
  input  logic        inValid,
  output rotPkg::vecT sampleVec,
  output rotPkg::vecT phasorVec,
  output logic        stageValid
);

  localparam int DEPTH = 1 << rotPkg::TABLE_W;

  logic [rotPkg::PHASE_W-1:0] acc;
  logic [rotPkg::PHASE_W-1:0] lanePhase [rotPkg::NUM_LANES];
  logic                       take;
  rotPkg::cplxT               rom [DEPTH];
  rotPkg::vecT                phasorNext;

  // ------------------------------------------------------------------
  // Table ROM, folded to constants at elaboration
  // ------------------------------------------------------------------
  for (genvar k = 0; k < DEPTH; k++) begin : romGen
    localparam rotPkg::cplxT ENTRY = rotPkg::phaseTable(k);
    assign rom[k] = ENTRY;
  end

  assign take = inValid && cfg.enable;

  // Lane i sits i steps past the accumulator
  always_comb begin
    for (int i = 0; i < rotPkg::NUM_LANES; i++) begin
      lanePhase[i]  = acc + cfg.freq * rotPkg::PHASE_W'(i);
      phasorNext[i] = rom[lanePhase[i][rotPkg::PHASE_W-1 -: rotPkg::TABLE_W]];
    end
  end

  // Load wins over the advance
  always_ff @(posedge clk) begin
    if (rst) begin
      acc <= '0;
    end else if (cfg.phaseLoad) begin
      acc <= cfg.phaseLoadValue;
    end else if (take) begin
      acc <= acc + cfg.freq * rotPkg::PHASE_W'(rotPkg::NUM_LANES);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) stageValid <= 1'b0;
    else     stageValid <= take;
  end

  // Samples and phasors leave together
  always_ff @(posedge clk) begin
    sampleVec <= inVec;
    phasorVec <= phasorNext;
  end

endmodule

//--- design/rotBank.sv
// Top level; samples arriving while disabled are dropped, output follows input by four cycles
`timescale 1ns/1ps

module rotBank (
  input  logic        clk,
  input  logic        rst,
  input  rotPkg::vecT inVec,
  input  logic        inValid,
  output rotPkg::vecT outVec,
  output logic        outValid,
  input  logic [2:0]  wbAdr,
  input  logic [31:0] wbDatW,
  input  logic        wbWe,
  input  logic        wbStb,
  input  logic        wbCyc,
  output logic [31:0] wbDatR,
  output logic        wbAck
);

  rotPkg::cfgT                                   cfg;
  logic [rotPkg::NUM_LANES-1:0][rotPkg::CNT_W-1:0] satCount;
  rotPkg::vecT                                   sampleVec;
  rotPkg::vecT                                   phasorVec;
  logic                                          stageValid;
  rotPkg::vecT                                   laneOutVec;
  logic [rotPkg::NUM_LANES-1:0]                  laneSat;
  logic [rotPkg::NUM_LANES-1:0]                  laneValid;  // All lanes run in step

  rotCtrl ctrl0 (
    .clk, .rst, .wbAdr, .wbDatW, .wbWe, .wbStb, .wbCyc,
    .satCount, .wbDatR, .wbAck, .cfg
  );

  phaseNco nco0 (
    .clk, .rst, .cfg, .inVec, .inValid,
    .sampleVec, .phasorVec, .stageValid
  );

  for (genvar i = 0; i < rotPkg::NUM_LANES; i++) begin : laneGen
    rotLane lane (
      .clk       (clk),
      .rst       (rst),
      .sample    (sampleVec[i]),
      .phasor    (phasorVec[i]),
      .valid     (stageValid),
      .laneOut   (laneOutVec[i]),
      .laneSat   (laneSat[i]),
      .laneValid (laneValid[i])
    );
  end

  laneCollect collect0 (
    .clk, .rst, .cfg,
    .laneOut   (laneOutVec),
    .laneSat   (laneSat),
    .laneValid (laneValid[0]),
    .outVec, .outValid, .satCount
  );

endmodule

//--- design/rotCtrl.sv
// Wishbone classic slave; one ack per strobe, a held strobe must drop before the next access
`timescale 1ns/1ps

module rotCtrl (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic [2:0]                                   wbAdr,
  input  logic [31:0]                                  wbDatW,
  input  logic                                         wbWe,
  input  logic                                         wbStb,
  input  logic                                         wbCyc,
  input  logic [rotPkg::NUM_LANES-1:0][rotPkg::CNT_W-1:0] satCount,
  output logic [31:0]                                  wbDatR,
  output logic                                         wbAck,
  output rotPkg::cfgT                                  cfg
);

  typedef enum logic {IDLE, ACK} stateE;

  stateE                       state;
  logic                        holdOff;   // Set after ack until stb drops
  logic [rotPkg::PHASE_W-1:0]  freqReg;
  logic                        enableReg;
  logic                        wrStrobe;
  rotPkg::wbRegE               regSel;

  assign regSel   = rotPkg::wbRegE'(wbAdr);
  assign wbAck    = (state == ACK);
  assign wrStrobe = wbAck && wbWe;

  // ------------------------------------------------------------------
  // Handshake
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      holdOff <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (wbStb && wbCyc && !holdOff) state <= ACK;
          if (!wbStb) holdOff <= 1'b0;
        end
        ACK: begin
          state   <= IDLE;
          holdOff <= 1'b1;  // Wait for master to release stb
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Register writes land at the end of the ack cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      freqReg   <= '0;
      enableReg <= 1'b0;
    end else if (wrStrobe) begin
      if (regSel == rotPkg::REG_FREQ) freqReg <= wbDatW[rotPkg::PHASE_W-1:0];
      if (regSel == rotPkg::REG_CTRL) enableReg <= wbDatW[0];
    end
  end

  // Strobes live only for the ack cycle
  assign cfg.freq           = freqReg;
  assign cfg.phaseLoad      = wrStrobe && (regSel == rotPkg::REG_PHASE);
  assign cfg.phaseLoadValue = wbDatW[rotPkg::PHASE_W-1:0];
  assign cfg.enable         = enableReg;
  assign cfg.satClear       = wrStrobe && (regSel == rotPkg::REG_CTRL) && wbDatW[1];

  // Read mux, valid while ack is high
  always_comb begin
    wbDatR = '0;
    case (regSel)
      rotPkg::REG_FREQ: wbDatR[rotPkg::PHASE_W-1:0] = freqReg;
      rotPkg::REG_CTRL: wbDatR[0] = enableReg;   // Clear bit reads back 0
      rotPkg::REG_SAT0: wbDatR[rotPkg::CNT_W-1:0] = satCount[0];
      rotPkg::REG_SAT1: wbDatR[rotPkg::CNT_W-1:0] = satCount[1];
      rotPkg::REG_SAT2: wbDatR[rotPkg::CNT_W-1:0] = satCount[2];
      rotPkg::REG_SAT3: wbDatR[rotPkg::CNT_W-1:0] = satCount[3];
      default: wbDatR = '0;  // Phase register is write only
    endcase
  end

endmodule

//--- design/rotLane.sv
// One complex multiply lane, two register stages, truncates to bits 18:9 and clips to +/-511
`timescale 1ns/1ps

module rotLane (
  input  logic         clk,
  input  logic         rst,
  input  rotPkg::cplxT sample,
  input  rotPkg::cplxT phasor,
  input  logic         valid,
  output rotPkg::cplxT laneOut,
  output logic         laneSat,
  output logic         laneValid
);

  localparam int HI = rotPkg::PROD_W - 2;             // Top kept bit
  localparam int LO = HI - rotPkg::SAMPLE_W + 1;

  // (a + bi)(c + di) = (ac - bd) + (bc + ad)i
  logic signed [rotPkg::PROD_W-1:0] ac, bd, bc, ad;
  logic signed [rotPkg::PROD_W:0]   sumRe, sumIm;
  logic                             prodValid;
  logic [rotPkg::SAMPLE_W:0]        clipRe, clipIm;  // {sat, value}

  // Keep HI:LO unless the guard bits disagree
  function automatic logic [rotPkg::SAMPLE_W:0] clip(input logic signed [rotPkg::PROD_W:0] s);
    logic [2:0] guard;
    guard = s[rotPkg::PROD_W -: 3];
    if (guard == 3'b000 || guard == 3'b111) return {1'b0, s[HI:LO]};
    if (s[rotPkg::PROD_W]) return {1'b1, rotPkg::SAMPLE_W'(-rotPkg::SAT_MAX)};
    return {1'b1, rotPkg::SAMPLE_W'(rotPkg::SAT_MAX)};
  endfunction

  // ------------------------------------------------------------------
  // Stage 1 products
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    ac <= sample.re * phasor.re;
    bd <= sample.im * phasor.im;
    bc <= sample.im * phasor.re;
    ad <= sample.re * phasor.im;
  end

  // ------------------------------------------------------------------
  // Stage 2 combine and clip
  // ------------------------------------------------------------------
  always_comb begin
    sumRe  = (rotPkg::PROD_W+1)'(ac) - (rotPkg::PROD_W+1)'(bd);
    sumIm  = (rotPkg::PROD_W+1)'(bc) + (rotPkg::PROD_W+1)'(ad);
    clipRe = clip(sumRe);
    clipIm = clip(sumIm);
  end

  always_ff @(posedge clk) begin
    laneOut.re <= clipRe[rotPkg::SAMPLE_W-1:0];
    laneOut.im <= clipIm[rotPkg::SAMPLE_W-1:0];
    laneSat    <= clipRe[rotPkg::SAMPLE_W] || clipIm[rotPkg::SAMPLE_W];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      prodValid <= 1'b0;
      laneValid <= 1'b0;
    end else begin
      prodValid <= valid;
      laneValid <= prodValid;
    end
  end

endmodule

//--- design/rotPkg.sv
// Shared widths, types and the cosine table; the table function is for elaboration-time use only
package rotPkg;

  // ------------------------------------------------------------------
  // Datapath sizes
  // ------------------------------------------------------------------
  localparam int NUM_LANES = 4;   // Samples per vector
  localparam int SAMPLE_W  = 10;
  localparam int PHASE_W   = 16;
  localparam int TABLE_W   = 10;  // Top bits of phase index the table
  localparam int PROD_W    = 20;
  localparam int SAT_MAX   = 511;
  localparam int AMP       = 511; // Table amplitude
  localparam int CNT_W     = 16;
  localparam int PIPE_LAT  = 4;   // NCO + two lane stages + collector

  typedef struct packed {
    logic signed [SAMPLE_W-1:0] re;
    logic signed [SAMPLE_W-1:0] im;
  } cplxT;

  typedef cplxT [NUM_LANES-1:0] vecT;

  // Word addresses of the register map
  typedef enum logic [2:0] {
    REG_FREQ  = 3'd0,
    REG_PHASE = 3'd1,
    REG_CTRL  = 3'd2,
    REG_SAT0  = 3'd3,
    REG_SAT1  = 3'd4,
    REG_SAT2  = 3'd5,
    REG_SAT3  = 3'd6
  } wbRegE;

  typedef struct packed {
    logic [PHASE_W-1:0] freq;           // Phase step per sample
    logic               phaseLoad;      // One-cycle load strobe
    logic [PHASE_W-1:0] phaseLoadValue;
    logic               enable;
    logic               satClear;       // One-cycle clear strobe
  } cfgT;

  // Round half away from zero
  function automatic int roundReal(input real x);
    if (x >= 0.0) return $rtoi(x + 0.5);
    return -$rtoi(0.5 - x);
  endfunction

  // AMP * (cos, sin) of 2*pi*k/1024
  function automatic cplxT phaseTable(input int k);
    real  ang;
    cplxT e;
    ang  = 2.0 * 3.14159265358979323846 * real'(k) / real'(1 << TABLE_W);
    e.re = SAMPLE_W'(roundReal(real'(AMP) * $cos(ang)));
    e.im = SAMPLE_W'(roundReal(real'(AMP) * $sin(ang)));
    return e;
  endfunction

endpackage

//--- rotBank.f
design/rotPkg.sv
design/rotCtrl.sv
design/phaseNco.sv
design/rotLane.sv
design/laneCollect.sv
design/rotBank.sv
sim/rotBank_assertions.sv
sim/rotBank_tb.sv

//--- sim/rotBank_assertions.sv
// Bound into every rotBank; assumes the master holds stb and cyc until it has seen ack
`timescale 1ns/1ps

module rotBank_assertions (
  input logic        clk,
  input logic        rst,
  input logic        inValid,
  input logic        outValid,
  input logic        wbStb,
  input logic        wbCyc,
  input logic        wbAck,
  input rotPkg::cfgT cfg
);

  int failCount = 0;  // Summed into the final tally

  // ------------------------------------------------------------------
  // Reset and bus handshake
  // ------------------------------------------------------------------
  resetQuiet: assert property (@(posedge clk) $past(rst) |-> !outValid && !wbAck && !cfg.enable)
    else begin
      $error("outValid, wbAck or enable high right after reset");
      failCount++;
    end

  ackAfterStrobe: assert property (@(posedge clk) disable iff (rst)
    wbAck |-> $past(wbStb && wbCyc))
    else begin
      $error("wbAck without stb and cyc in the cycle before");
      failCount++;
    end

  // A fresh strobe is answered in the very next cycle
  ackPrompt: assert property (@(posedge clk) disable iff (rst)
    $rose(wbStb && wbCyc) |=> wbAck)
    else begin
      $error("no wbAck in the cycle after the strobe rose");
      failCount++;
    end

  ackSingle: assert property (@(posedge clk) disable iff (rst) wbAck |-> !$past(wbAck))
    else begin
      $error("wbAck held for more than one cycle");
      failCount++;
    end

  // ------------------------------------------------------------------
  // Sample path latency
  // ------------------------------------------------------------------
  latency: assert property (@(posedge clk) disable iff (rst)
    $past(inValid && cfg.enable, rotPkg::PIPE_LAT) |-> outValid)
    else begin
      $error("enabled input did not reach the output after PIPE_LAT cycles");
      failCount++;
    end

  noStray: assert property (@(posedge clk) disable iff (rst)
    outValid |-> $past(inValid && cfg.enable, rotPkg::PIPE_LAT))
    else begin
      $error("outValid without an enabled input PIPE_LAT cycles earlier");
      failCount++;
    end

endmodule

bind rotBank rotBank_assertions chk0 (
  .clk, .rst, .inValid, .outValid, .wbStb, .wbCyc, .wbAck, .cfg
);

//--- sim/rotBank_tb.sv
// Needs timing support and the bound checker chk0; stimulus changes 1 ns after each rising edge
`timescale 1ns/1ps

module rotBank_tb;

  localparam int TIMEOUT = 100;  // Cycles allowed per wait

  logic        clk, rst, inValid, outValid;
  logic        wbWe, wbStb, wbCyc, wbAck;
  logic [2:0]  wbAdr;
  logic [31:0] wbDatW, wbDatR;
  rotPkg::vecT inVec, outVec, expHead;
  rotPkg::vecT expQ [$];               // Expected output vectors in order
  logic [15:0] mPhase = '0;            // Model accumulator
  logic [15:0] mFreq = '0;
  logic        mEnable = 1'b0;
  int          errors = 0, tests = 0, failedTests = 0, errMark = 0;

  rotBank dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------
  // Floor divide by 512, clip only when the result leaves -512..511
  function automatic logic [9:0] truncSat(input int x);
    if ((x >>> 9) > 511) return 10'(511);
    if ((x >>> 9) < -512) return 10'(-511);
    return 10'(x >>> 9);
  endfunction

  // Lane i turns by 511 * exp(j*2*pi*k/1024), k the top ten bits of ph + i*freq
  function automatic rotPkg::vecT expectVec(input rotPkg::vecT v, input logic [15:0] ph);
    rotPkg::vecT e;
    logic [15:0] p;
    real         ang;
    int          c, s;
    for (int i = 0; i < rotPkg::NUM_LANES; i++) begin
      p   = ph + mFreq * 16'(i);
      ang = 6.283185307179586 * real'(p[15:6]) / 1024.0;
      c   = $rtoi($floor(511.0 * $cos(ang) + 0.5));
      s   = $rtoi($floor(511.0 * $sin(ang) + 0.5));
      e[i].re = truncSat(v[i].re * c - v[i].im * s);
      e[i].im = truncSat(v[i].im * c + v[i].re * s);
    end
    return e;
  endfunction

  // One classic cycle; a read is checked against data, a write updates the model
  task automatic wbAccess(input logic [2:0] adr, input logic we, input logic [31:0] data);
    int n;
    {wbAdr, wbDatW, wbWe, wbStb, wbCyc} = {adr, data, we, 2'b11};
    n = 0;
    do begin
      @(posedge clk);
      #1 n++;
    end while (!wbAck && n < TIMEOUT);
    if (!wbAck) begin
      $display("No Wishbone ack for address %0d within %0d cycles", adr, TIMEOUT);
      errors++;
    end else if (!we) begin
      assert (wbDatR == data) else begin
        $display("Error %0t: register %0d read %h, expected %h", $time, adr, wbDatR, data);
        errors++;
      end
    end
    if (we && adr == rotPkg::REG_FREQ) mFreq = data[15:0];
    if (we && adr == rotPkg::REG_PHASE) mPhase = data[15:0];
    if (we && adr == rotPkg::REG_CTRL) mEnable = data[0];
    @(posedge clk);  // Write lands on this edge
    #1 {wbWe, wbStb, wbCyc} = 3'b000;
    @(posedge clk);  // Slave needs to see stb low
    #1;
  endtask

  // Back-to-back vectors, random or 511 - 512i on every lane, then wait for the queue
  task automatic sendVecs(input int count, input logic satInput);
    int n;
    for (int k = 0; k < count; k++) begin
      for (int i = 0; i < rotPkg::NUM_LANES; i++) begin
        inVec[i].re = satInput ? 10'(511) : 10'($urandom);
        inVec[i].im = satInput ? 10'(-512) : 10'($urandom);
      end
      inValid = 1'b1;
      if (mEnable) begin
        expQ.push_back(expectVec(inVec, mPhase));
        mPhase = mPhase + 16'(rotPkg::NUM_LANES) * mFreq;
      end
      @(posedge clk);
      #1;
    end
    inValid = 1'b0;
    n = 0;
    while (expQ.size() != 0 && n < TIMEOUT) begin
      @(posedge clk);
      #1 n++;
    end
    if (expQ.size() != 0) begin
      $display("Timed out with %0d vectors missing at the output", expQ.size());
      errors++;
      expQ.delete();
    end
  endtask

  // Mid-cycle compare against the head of the queue
  always @(negedge clk) begin
    if (!rst && outValid && expQ.size() == 0) begin
      $display("Output vector appeared at %0t with none expected", $time);
      errors++;
    end else if (!rst && outValid) begin
      expHead = expQ.pop_front();
      assert (outVec == expHead) else begin
        $display("Error %0t: outVec %h, expected %h", $time, outVec, expHead);
        errors++;
      end
    end
  end

  function automatic int totalErrors();
    return errors + dut0.chk0.failCount;
  endfunction

  task automatic endTest(input string name);
    tests++;
    if (totalErrors() != errMark) failedTests++;
    $display("%s: %s", name, (totalErrors() == errMark) ? "ok" : "FAILED");
    errMark = totalErrors();
  endtask

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------
  initial begin
    void'($urandom(32'h7628cdc4));
    rst = 1'b1;
    {inValid, wbWe, wbStb, wbCyc, wbAdr, wbDatW, inVec} = '0;
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
    assert (!outValid && !wbAck) else begin
      $display("Error %0t: outValid or wbAck high after reset", $time);
      errors++;
    end
    for (int i = 0; i < 4; i++) wbAccess(3'(int'(rotPkg::REG_SAT0) + i), 1'b0, 32'd0);
    endTest("reset state");

    wbAccess(rotPkg::REG_FREQ, 1'b1, 32'h0000_1234);
    wbAccess(rotPkg::REG_FREQ, 1'b0, 32'h0000_1234);
    endTest("register access");

    wbAccess(rotPkg::REG_FREQ, 1'b1, 32'd0);
    wbAccess(rotPkg::REG_PHASE, 1'b1, 32'd0);
    wbAccess(rotPkg::REG_CTRL, 1'b1, 32'd1);
    sendVecs(12, 1'b0);
    endTest("zero frequency");

    wbAccess(rotPkg::REG_FREQ, 1'b1, {16'd0, 16'($urandom)});
    wbAccess(rotPkg::REG_PHASE, 1'b1, {16'd0, 16'($urandom)});
    sendVecs(20, 1'b0);
    endTest("rotation");

    wbAccess(rotPkg::REG_FREQ, 1'b1, 32'd0);
    wbAccess(rotPkg::REG_PHASE, 1'b1, 32'h0000_2000);  // Index 128, 45 degrees
    wbAccess(rotPkg::REG_CTRL, 1'b1, 32'd3);           // Clear counters, stay enabled
    sendVecs(1, 1'b1);
    for (int i = 0; i < 4; i++) wbAccess(3'(int'(rotPkg::REG_SAT0) + i), 1'b0, 32'd1);
    wbAccess(rotPkg::REG_CTRL, 1'b1, 32'd3);
    for (int i = 0; i < 4; i++) wbAccess(3'(int'(rotPkg::REG_SAT0) + i), 1'b0, 32'd0);
    endTest("saturation");

    wbAccess(rotPkg::REG_FREQ, 1'b1, 32'h0000_0321);
    wbAccess(rotPkg::REG_CTRL, 1'b1, 32'd0);
    sendVecs(6, 1'b0);                        // Dropped, nothing queued
    wbAccess(rotPkg::REG_CTRL, 1'b1, 32'd1);
    sendVecs(4, 1'b0);                        // Model phase stood still meanwhile
    endTest("enable");

    $display("tests %0d, failed %0d, errors %0d", tests, failedTests, totalErrors());
    if (totalErrors() == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
